//--- vlog.f
+incdir+common
common/eeprom_pkg.sv
hdl/eeprom_dispatch.sv
eeprom_master/i2c_bit_ctrl.sv
eeprom_master/eeprom_master.sv
hdl/eeprom_collect.sv
hdl/eeprom_subsys.sv
bench/eeprom_model.sv
bench/tb_eeprom_subsys.sv

//--- bench/tb_eeprom_subsys.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module tb_eeprom_subsys;
    import eeprom_pkg::*;

    localparam int NCH     = `EE_NUM_CH;
    localparam int NUM_TXN = 14;
    // 40 bit times per transaction plus margin
    localparam int TIMEOUT_CYCLES = NUM_TXN * 40 * 4 * `EE_QUARTER + 1000;

    logic           CLK;
    logic           RESET;
    logic           req_valid;
    logic           req_ready;
    ee_ch_t         req_ch;
    logic           req_wr;
    ee_addr_t       req_addr;
    ee_byte_t       req_wdata;
    logic           rsp_valid;
    logic           rsp_ready;
    ee_ch_t         rsp_ch;
    ee_byte_t       rsp_rdata;
    logic           rsp_err;
    logic [NCH-1:0] scl;
    logic [NCH-1:0] sda_oe;
    logic [NCH-1:0] sda_line;
    logic [NCH-1:0] model_oe;
    logic [NCH-1:0] nack;

    ee_byte_t       sb [NCH][2048];  // mirror of each model memory
    logic [NCH-1:0] busy;
    ee_byte_t       exp_rdata [NCH];
    logic [NCH-1:0] exp_err;
    int             errors;
    int             test_errs;
    int             n_req;
    int             n_rsp;
    int             cycles;
    logic           stall;
    ee_ch_t         stall_ch;
    ee_byte_t       stall_rdata;
    logic           stall_err;
    ee_addr_t       addrs [3];

    always #10 CLK = ~CLK;

    eeprom_subsys i_eeprom_subsys (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_ch    (req_ch),
        .req_wr    (req_wr),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_ch    (rsp_ch),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_line)
    );

    assign sda_line = ~(sda_oe | model_oe);  // pulled up and low while either side pulls

    for (genvar g = 0; g < NCH; g++)
    begin : g_bus
        eeprom_model i_model (
            .CLK    (CLK),
            .scl    (scl[g]),
            .sda    (sda_line[g]),
            .nack   (nack[g]),
            .sda_oe (model_oe[g])
        );
    end

    function automatic ee_byte_t fill_byte(int a);
        return ee_byte_t'(a ^ (a >> 3));
    endfunction

    task automatic flag_mismatch(input string sig, input int exp_v, input int act_v);
        $display("[FAIL] %0d ns %s expected %h got %h", $time, sig, exp_v, act_v);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("%0d ns %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errs)
            $display("%-22s ok", name);
        else
            $display("%-22s %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    // returns 1 ns after the edge that accepted the request
    task automatic send_req(input int ch, input logic wr, input ee_addr_t a, input ee_byte_t d);
        req_valid = 1'b1;
        req_ch    = ee_ch_t'(ch);
        req_wr    = wr;
        req_addr  = a;
        req_wdata = d;
        @(posedge CLK);
        while (!req_ready)
            @(posedge CLK);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy != '0)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            if (stall)
            begin
                assert (rsp_valid) else flag_mismatch("rsp_valid", 1, rsp_valid);
                assert (rsp_ch === stall_ch) else flag_mismatch("rsp_ch", stall_ch, rsp_ch);
                assert (rsp_rdata === stall_rdata)
                    else flag_mismatch("rsp_rdata", stall_rdata, rsp_rdata);
                assert (rsp_err === stall_err) else flag_mismatch("rsp_err", stall_err, rsp_err);
            end
            if (req_valid && busy[req_ch])
                assert (!req_ready) else flag_mismatch("req_ready", 0, req_ready);
            if (req_valid && req_ready)
            begin
                busy[req_ch]      = 1'b1;
                exp_err[req_ch]   = nack[req_ch];
                exp_rdata[req_ch] = 8'h00;
                if (!nack[req_ch] && req_wr)
                    sb[req_ch][req_addr] = req_wdata;
                else if (!nack[req_ch])
                    exp_rdata[req_ch] = sb[req_ch][req_addr];
                n_req++;
            end
            if (rsp_valid && rsp_ready)
            begin
                assert (busy[rsp_ch])
                    else report_error($sformatf("no request outstanding on channel %0d",
                                                rsp_ch));
                if (busy[rsp_ch])
                begin
                    assert (rsp_rdata === exp_rdata[rsp_ch])
                        else flag_mismatch("rsp_rdata", exp_rdata[rsp_ch], rsp_rdata);
                    assert (rsp_err === exp_err[rsp_ch])
                        else flag_mismatch("rsp_err", exp_err[rsp_ch], rsp_err);
                end
                busy[rsp_ch] = 1'b0;
                n_rsp++;
            end
        end
        stall       = !RESET && rsp_valid && !rsp_ready;
        stall_ch    = rsp_ch;
        stall_rdata = rsp_rdata;
        stall_err   = rsp_err;
    end

    initial
    begin
        ee_addr_t a;
        ee_byte_t d;
        int       hold;
        void'($urandom(90387));
        CLK       = 1'b0;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req_ch    = '0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        nack      = '0;
        busy      = '0;
        stall     = 1'b0;
        errors    = 0;
        test_errs = 0;
        n_req     = 0;
        n_rsp     = 0;
        for (int c = 0; c < NCH; c++)
            for (int i = 0; i < 2048; i++)
                sb[c][i] = fill_byte(i);
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;

        for (int c = 0; c < NCH; c++)
        begin
            req_ch = ee_ch_t'(c);
            @(posedge CLK);
            assert (req_ready === 1'b1) else flag_mismatch("req_ready", 1, req_ready);
            #1;
        end
        assert (rsp_valid === 1'b0) else flag_mismatch("rsp_valid", 0, rsp_valid);
        assert (scl === '1) else flag_mismatch("scl", (1 << NCH) - 1, scl);
        assert (sda_oe === '0) else flag_mismatch("sda_oe", 0, sda_oe);
        end_test("reset_state");

        for (int i = 0; i < 3; i++)
        begin
            addrs[i] = ee_addr_t'($urandom);
            send_req(i % NCH, 1'b1, addrs[i], ee_byte_t'($urandom));
        end
        wait_idle();
        for (int i = 0; i < 3; i++)
            send_req(i % NCH, 1'b0, addrs[i], 8'h00);
        wait_idle();
        end_test("write_read");

        a = ee_addr_t'($urandom);
        d = ee_byte_t'($urandom);
        send_req(0, 1'b1, a, d);
        send_req(NCH - 1, 1'b1, a, ~d);
        wait_idle();
        send_req(0, 1'b0, a, 8'h00);
        send_req(NCH - 1, 1'b0, a, 8'h00);
        wait_idle();
        end_test("channel_independence");

        nack[NCH - 1] = 1'b1;
        send_req(NCH - 1, 1'b1, addrs[1], ~sb[NCH - 1][addrs[1]]);
        wait_idle();
        nack = '0;
        send_req(NCH - 1, 1'b0, addrs[1], 8'h00);  // memory must be untouched
        wait_idle();
        end_test("nack");

        rsp_ready = 1'b0;
        send_req(0, 1'b0, addrs[0], 8'h00);
        while (!rsp_valid)
        begin
            @(posedge CLK);
            #1;
        end
        req_valid = 1'b1;  // same channel is refused until the response drains
        req_ch    = '0;
        req_wr    = 1'b0;
        req_addr  = addrs[2];
        req_wdata = 8'h00;
        hold      = 4 + $urandom % 24;
        repeat (hold) @(posedge CLK);
        #1;
        rsp_ready = 1'b1;
        @(posedge CLK);
        while (!req_ready)
            @(posedge CLK);
        #1;
        req_valid = 1'b0;
        wait_idle();
        end_test("back_pressure");

        assert (n_req == NUM_TXN && n_rsp == n_req)
            else report_error($sformatf("%0d requests and %0d responses, %0d expected",
                                        n_req, n_rsp, NUM_TXN));
        $display("tests 5, requests %0d, responses %0d, errors %0d", n_req, n_rsp, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("run timed out after %0d cycles and did not finish", cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- bench/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic nack,     // refuse every byte while high
    output logic sda_oe
);
    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_CTRL = 3'd1;
    localparam logic [2:0] S_ADDR = 3'd2;
    localparam logic [2:0] S_DATA = 3'd3;
    localparam logic [2:0] S_SEND = 3'd4;

    logic [7:0]  mem [2048];
    logic [2:0]  st;
    logic [3:0]  bits;
    logic        ack_slot;   // ninth clock of a byte
    logic        acked;
    logic        ack_ok;
    logic        rw;
    logic [7:0]  shreg;
    logic [2:0]  blk;        // a[10:8] from the control byte
    logic [10:0] ptr;
    logic        scl_d;
    logic        sda_d;

    assign ack_ok = !nack && (st != S_CTRL || shreg[7:4] == `EE_DEV_CODE);

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3));  // every address bit shows up
        st       = S_IDLE;
        bits     = 4'd0;
        ack_slot = 1'b0;
        sda_oe   = 1'b0;
        scl_d    = 1'b1;
        sda_d    = 1'b1;
    end

    // bus is oversampled on CLK, edges found from the previous sample
    always @(posedge CLK)
    begin
        scl_d <= scl;
        sda_d <= sda;
        if (scl && scl_d && sda_d && !sda)
        begin
            st       <= S_CTRL;  // start or repeated start
            bits     <= 4'd0;
            ack_slot <= 1'b0;
            sda_oe   <= 1'b0;
        end
        else if (scl && scl_d && !sda_d && sda)
        begin
            st     <= S_IDLE;  // stop
            sda_oe <= 1'b0;
        end
        else if (scl && !scl_d && st != S_IDLE)
        begin
            if (ack_slot)
            begin
                if (st == S_SEND)
                    st <= S_IDLE;  // no sequential reads
            end
            else
            begin
                shreg <= (st == S_SEND) ? {shreg[6:0], 1'b0} : {shreg[6:0], sda};
                bits  <= bits + 4'd1;
            end
        end
        else if (!scl && scl_d && st != S_IDLE)
        begin
            if (ack_slot)
            begin
                ack_slot <= 1'b0;
                bits     <= 4'd0;
                sda_oe   <= 1'b0;
                if (!acked)
                    st <= S_IDLE;
                else if (st == S_CTRL && rw)
                begin
                    st     <= S_SEND;
                    shreg  <= mem[ptr];
                    sda_oe <= ~mem[ptr][7];
                end
                else if (st == S_CTRL)
                    st <= S_ADDR;
                else if (st == S_ADDR)
                    st <= S_DATA;
                else
                    st <= S_IDLE;  // one byte per write
            end
            else if (bits == 4'd8)
            begin
                ack_slot <= 1'b1;
                acked    <= ack_ok;
                sda_oe   <= ack_ok && st != S_SEND;
                case (st)
                    S_CTRL:
                    begin
                        blk <= shreg[3:1];
                        rw  <= shreg[0];
                    end
                    S_ADDR:  ptr <= {blk, shreg};
                    S_DATA:  if (ack_ok) mem[ptr] <= shreg;
                    default: ;
                endcase
            end
            else if (st == S_SEND)
                sda_oe <= ~shreg[7];
        end
    end

endmodule

//--- hdl/eeprom_subsys.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_subsys (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  eeprom_pkg::ee_ch_t    req_ch,
    input  logic                  req_wr,
    input  eeprom_pkg::ee_addr_t  req_addr,
    input  eeprom_pkg::ee_byte_t  req_wdata,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output eeprom_pkg::ee_ch_t    rsp_ch,
    output eeprom_pkg::ee_byte_t  rsp_rdata,
    output logic                  rsp_err,
    output logic [`EE_NUM_CH-1:0] scl,
    output logic [`EE_NUM_CH-1:0] sda_oe,
    input  logic [`EE_NUM_CH-1:0] sda_in
);
    import eeprom_pkg::*;

    logic [`EE_NUM_CH-1:0] ch_req_valid;
    logic [`EE_NUM_CH-1:0] ch_req_ready;
    logic [`EE_NUM_CH-1:0] ch_rsp_valid;
    logic [`EE_NUM_CH-1:0] ch_rsp_ready;
    logic [`EE_NUM_CH-1:0] ch_rsp_err;
    ee_byte_t              ch_rsp_rdata [`EE_NUM_CH];

    eeprom_dispatch i_dispatch (
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_ch       (req_ch),
        .ch_req_valid (ch_req_valid),
        .ch_req_ready (ch_req_ready)
    );

    // request fields go to every master, only the valid is per channel
    for (genvar g = 0; g < `EE_NUM_CH; g++)
    begin : g_ch
        eeprom_master i_master (
            .CLK       (CLK),
            .RESET     (RESET),
            .req_valid (ch_req_valid[g]),
            .req_ready (ch_req_ready[g]),
            .req_wr    (req_wr),
            .req_addr  (req_addr),
            .req_wdata (req_wdata),
            .rsp_valid (ch_rsp_valid[g]),
            .rsp_ready (ch_rsp_ready[g]),
            .rsp_rdata (ch_rsp_rdata[g]),
            .rsp_err   (ch_rsp_err[g]),
            .scl       (scl[g]),
            .sda_oe    (sda_oe[g]),
            .sda_in    (sda_in[g])
        );
    end

    eeprom_collect i_collect (
        .CLK          (CLK),
        .RESET        (RESET),
        .ch_rsp_valid (ch_rsp_valid),
        .ch_rsp_ready (ch_rsp_ready),
        .ch_rsp_rdata (ch_rsp_rdata),
        .ch_rsp_err   (ch_rsp_err),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_ch       (rsp_ch),
        .rsp_rdata    (rsp_rdata),
        .rsp_err      (rsp_err)
    );

endmodule

//--- hdl/eeprom_collect.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_collect (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [`EE_NUM_CH-1:0] ch_rsp_valid,
    output logic [`EE_NUM_CH-1:0] ch_rsp_ready,
    input  eeprom_pkg::ee_byte_t  ch_rsp_rdata [`EE_NUM_CH],
    input  logic [`EE_NUM_CH-1:0] ch_rsp_err,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output eeprom_pkg::ee_ch_t    rsp_ch,
    output eeprom_pkg::ee_byte_t  rsp_rdata,
    output logic                  rsp_err
);
    import eeprom_pkg::*;

    ee_ch_t ptr;      // highest priority channel
    ee_ch_t pick;
    ee_ch_t sel;
    ee_ch_t lock_ch;
    logic   locked;   // keeps the grant while rsp_ready is low

    // walk down so the first valid at or after ptr wins
    always_comb
    begin
        int idx;
        pick = ptr;
        for (int i = `EE_NUM_CH - 1; i >= 0; i--)
        begin
            idx = (int'(ptr) + i) % `EE_NUM_CH;
            if (ch_rsp_valid[idx])
                pick = ee_ch_t'(idx);
        end
    end

    assign sel       = locked ? lock_ch : pick;
    assign rsp_valid = ch_rsp_valid[sel];
    assign rsp_ch    = sel;
    assign rsp_rdata = ch_rsp_rdata[sel];
    assign rsp_err   = ch_rsp_err[sel];

    always_comb
    begin
        ch_rsp_ready = '0;
        ch_rsp_ready[sel] = rsp_ready && rsp_valid;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            ptr    <= '0;
            locked <= 1'b0;
        end
        else
        begin
            locked <= rsp_valid && !rsp_ready;
            if (rsp_valid && rsp_ready)
                ptr <= (int'(sel) == `EE_NUM_CH - 1) ? '0 : ee_ch_t'(sel + 1'b1);
        end
    end

    always_ff @(posedge CLK)
        lock_ch <= sel;

endmodule

//--- eeprom_master/eeprom_master.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_master (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 req_wr,
    input  eeprom_pkg::ee_addr_t req_addr,
    input  eeprom_pkg::ee_byte_t req_wdata,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output eeprom_pkg::ee_byte_t rsp_rdata,
    output logic                 rsp_err,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    master_state_t state;
    logic          wait_op;    // op issued, waiting for op_done
    logic [3:0]    bcnt;       // 8 is the ack slot
    ee_byte_t      sh_out;
    ee_byte_t      rx_data;
    logic          r_wr;
    ee_addr_t      r_addr;
    ee_byte_t      r_wdata;
    logic          err;
    logic          ack_slot;

    logic          op_start;
    bit_op_t       op_code;
    logic          op_wbit;
    logic          op_done;
    logic          op_rbit;

    assign ack_slot  = (bcnt == 4'd8);
    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESP);
    assign rsp_err   = err;
    assign rsp_rdata = (r_wr || err) ? '0 : rx_data;

    assign op_start = !wait_op && (state != IDLE) && (state != RESP);
    assign op_wbit  = (state == DATA_R) ? 1'b1 : sh_out[7];  // nack after the read byte

    always_comb
    begin
        case (state)
            START, RESTART: op_code = OP_START;
            STOP:           op_code = OP_STOP;
            DATA_R:         op_code = ack_slot ? OP_WRITE : OP_READ;
            default:        op_code = ack_slot ? OP_READ : OP_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            wait_op <= 1'b0;
            bcnt    <= 4'd0;
            err     <= 1'b0;
        end
        else
        begin
            if (op_start)
                wait_op <= 1'b1;
            case (state)
                IDLE:
                    if (req_valid)
                    begin
                        r_wr    <= req_wr;
                        r_addr  <= req_addr;
                        r_wdata <= req_wdata;
                        err     <= 1'b0;
                        state   <= START;
                    end
                RESP:
                    if (rsp_ready)
                        state <= IDLE;
                default:
                    if (op_done)
                    begin
                        wait_op <= 1'b0;
                        case (state)
                            START:
                            begin
                                sh_out <= {`EE_DEV_CODE, r_addr[10:8], 1'b0};
                                bcnt   <= 4'd0;
                                state  <= CTRL_W;
                            end
                            RESTART:
                            begin
                                sh_out <= {`EE_DEV_CODE, r_addr[10:8], 1'b1};
                                bcnt   <= 4'd0;
                                state  <= CTRL_R;
                            end
                            DATA_R:
                                if (!ack_slot)
                                begin
                                    rx_data <= {rx_data[6:0], op_rbit};
                                    bcnt    <= bcnt + 4'd1;
                                end
                                else
                                    state <= STOP;
                            STOP:
                                state <= RESP;
                            default:  // byte out, ack in
                                if (!ack_slot)
                                begin
                                    sh_out <= {sh_out[6:0], 1'b0};
                                    bcnt   <= bcnt + 4'd1;
                                end
                                else
                                begin
                                    bcnt <= 4'd0;
                                    if (op_rbit)
                                    begin
                                        err   <= 1'b1;  // nack, go straight to stop
                                        state <= STOP;
                                    end
                                    else if (state == CTRL_W)
                                    begin
                                        sh_out <= r_addr[7:0];
                                        state  <= ADDR;
                                    end
                                    else if (state == ADDR)
                                    begin
                                        sh_out <= r_wdata;
                                        state  <= r_wr ? DATA_W : RESTART;
                                    end
                                    else if (state == DATA_W)
                                        state <= STOP;
                                    else
                                        state <= DATA_R;
                                end
                        endcase
                    end
            endcase
        end
    end

    i2c_bit_ctrl i_bit_ctrl (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_start (op_start),
        .op_code  (op_code),
        .op_wbit  (op_wbit),
        .op_done  (op_done),
        .op_rbit  (op_rbit),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

//--- eeprom_master/i2c_bit_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module i2c_bit_ctrl (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_start,
    input  eeprom_pkg::bit_op_t op_code,
    input  logic                op_wbit,
    output logic                op_done,
    output logic                op_rbit,
    output logic                scl,
    output logic                sda_oe,
    input  logic                sda_in
);
    import eeprom_pkg::*;

    localparam int QW = (`EE_QUARTER > 1) ? $clog2(`EE_QUARTER) : 1;

    logic          busy;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    bit_op_t       cur_op;
    logic          cur_wbit;
    logic          q_end;

    assign q_end = (qcnt == QW'(`EE_QUARTER - 1));

    // {scl, sda_oe} for one quarter of an operation
    function automatic logic [1:0] wave(bit_op_t op, logic wbit, logic [1:0] ph, logic scl_now);
        logic hi;
        logic [1:0] w;
        hi = (ph == 2'd1) || (ph == 2'd2);
        case (op)
            OP_START:  // keeps scl as is in quarter 0, so restart works too
                case (ph)
                    2'd0:    w = {scl_now, 1'b0};
                    2'd1:    w = 2'b10;
                    2'd2:    w = 2'b11;    // sda falls, scl high
                    default: w = 2'b01;
                endcase
            OP_STOP:
                case (ph)
                    2'd0:    w = 2'b01;
                    2'd1:    w = 2'b11;
                    default: w = 2'b10;    // sda rises, scl high
                endcase
            OP_WRITE: w = {hi, ~wbit};     // data set while scl low
            default:  w = {hi, 1'b0};      // read, sda released
        endcase
        return w;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (op_start)
                begin
                    busy  <= 1'b1;
                    qcnt  <= '0;
                    phase <= 2'd0;
                    {scl, sda_oe} <= wave(op_code, op_wbit, 2'd0, scl);
                end
            end
            else if (q_end)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3)
                begin
                    busy    <= 1'b0;
                    op_done <= 1'b1;
                end
                else
                    {scl, sda_oe} <= wave(cur_op, cur_wbit, phase + 2'd1, scl);
            end
            else
                qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && op_start)
        begin
            cur_op   <= op_code;
            cur_wbit <= op_wbit;
        end
        if (busy && q_end && phase == 2'd1 && cur_op == OP_READ)
            op_rbit <= sda_in;  // middle of scl high
    end

endmodule

//--- hdl/eeprom_dispatch.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_dispatch (
    input  logic                  req_valid,
    output logic                  req_ready,
    input  eeprom_pkg::ee_ch_t    req_ch,
    output logic [`EE_NUM_CH-1:0] ch_req_valid,
    input  logic [`EE_NUM_CH-1:0] ch_req_ready
);
    import eeprom_pkg::*;

    // one-hot valid toward the addressed master only
    always_comb
    begin
        for (int i = 0; i < `EE_NUM_CH; i++)
        begin
            ch_req_valid[i] = req_valid && (req_ch == ee_ch_t'(i));
        end
    end

    // ready follows the addressed channel, so a busy one blocks nobody else
    assign req_ready = ch_req_ready[req_ch];

endmodule

//--- common/eeprom_pkg.sv
`include "eeprom_defs.svh"

package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;  // a[10:8] go into the control byte
    typedef logic [7:0]  ee_byte_t;
    typedef logic [$clog2(`EE_NUM_CH)-1:0] ee_ch_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bit_op_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        RESP
    } master_state_t;

endpackage

//--- common/eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// channel masters, one two-wire bus each
`define EE_NUM_CH 2

// CLK cycles per quarter of an SCL period
`define EE_QUARTER 4

// top nibble of every control byte
`define EE_DEV_CODE 4'b1010

`endif
